//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := bp_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard rtl/*.sv) $(wildcard sim/*.sv)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail, not the simulator exit code
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/bp_btb_fill.sv
module bp_btb_fill import bp_pkg::*; #(
    parameter int unsigned num_sets = 16,
    parameter int unsigned num_ways = 2
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                update_i,
    input  logic [xlen-1:0]     update_pc_i,
    input  logic [num_ways-1:0] update_match_i,
    output logic [num_ways-1:0] way_write_o
);

    localparam int unsigned set_bits = $clog2(num_sets);
    // a single way still gets a one bit pointer that simply stays at zero
    localparam int unsigned ptr_bits = (num_ways > 1) ? $clog2(num_ways) : 1;

    // round-robin victim pointer for every set
    logic [ptr_bits-1:0] rr_ptr_q [num_sets];

    logic [set_bits-1:0] update_set;
    logic                update_hit;
    logic [ptr_bits-1:0] victim;

    assign update_set = update_pc_i[pc_offset_bits +: set_bits];
    assign update_hit = |update_match_i;
    assign victim     = rr_ptr_q[update_set];

    // an entry that already holds this tag is rewritten where it sits
    // otherwise the set's pointer names the way that gets replaced
    always_comb begin
        way_write_o = '0;
        if (update_i) begin
            if (update_hit) begin
                way_write_o = update_match_i;
            end else begin
                way_write_o[victim] = 1'b1;
            end
        end
    end

    // only an allocation moves the pointer on
    // an in-place rewrite leaves the replacement order of the set untouched
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < num_sets; s++) begin
                rr_ptr_q[s] <= '0;
            end
        end else if (update_i && !update_hit) begin
            if (victim == ptr_bits'(num_ways - 1)) begin
                rr_ptr_q[update_set] <= '0;
            end else begin
                rr_ptr_q[update_set] <= victim + 1'b1;
            end
        end
    end

    // the ways must never hold the same tag twice in a set
    // otherwise more than one way would be written by a rewrite
    a_write_onehot: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(way_write_o));

endmodule

//--- rtl/bp_btb_way.sv
module bp_btb_way import bp_pkg::*; #(
    parameter int unsigned num_sets = 16
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic [xlen-1:0] lookup_pc_i,
    input  logic [xlen-1:0] update_pc_i,
    input  logic [xlen-1:0] update_target_i,
    input  logic            write_i,
    output logic            lookup_hit_o,
    output logic [xlen-1:0] lookup_target_o,
    output logic            update_match_o
);

    // set index sits just above the ignored low PC bits
    localparam int unsigned set_bits = $clog2(num_sets);
    // everything above the set index forms the tag
    localparam int unsigned tag_bits = xlen - pc_offset_bits - set_bits;

    // one entry per set holds a full target, the tag and a valid flag
    logic [xlen-1:0]     target_q [num_sets];
    logic [tag_bits-1:0] tag_q    [num_sets];
    logic [num_sets-1:0] valid_q;

    logic [set_bits-1:0] lookup_set;
    logic [tag_bits-1:0] lookup_tag;
    logic [set_bits-1:0] update_set;
    logic [tag_bits-1:0] update_tag;

    // split both addresses into set index and tag
    assign lookup_set = lookup_pc_i[pc_offset_bits +: set_bits];
    assign lookup_tag = lookup_pc_i[xlen-1 -: tag_bits];
    assign update_set = update_pc_i[pc_offset_bits +: set_bits];
    assign update_tag = update_pc_i[xlen-1 -: tag_bits];

    // fetch side compare
    // the target is driven even on a miss and the merge stage ignores it then
    assign lookup_hit_o    = valid_q[lookup_set] && (tag_q[lookup_set] == lookup_tag);
    assign lookup_target_o = target_q[lookup_set];

    // resolve side compare
    // the fill logic uses this to rewrite a resident entry in place
    assign update_match_o = valid_q[update_set] && (tag_q[update_set] == update_tag);

    // valid bits are the only state that has to be cleared
    // a stale target or tag behind a clear valid bit can never produce a hit
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (write_i) begin
            valid_q[update_set] <= 1'b1;
        end
    end

    // payload storage
    // a write replaces both fields of the selected set in the same edge
    always_ff @(posedge clk) begin
        if (write_i) begin
            target_q[update_set] <= update_target_i;
            tag_q[update_set]    <= update_tag;
        end
    end

endmodule

//--- rtl/bp_gshare.sv
module bp_gshare import bp_pkg::*; #(
    parameter int unsigned num_ghr_bits = 5
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [xlen-1:0]         pc_i,
    input  logic                    update_i,
    input  logic [num_ghr_bits-1:0] update_index_i,
    input  logic                    taken_i,
    input  logic                    ghr_clear_i,
    output logic [num_ghr_bits-1:0] pht_index_o,
    output logic                    pht_taken_o
);

    localparam int unsigned num_counters = 2 ** num_ghr_bits;

    // global history with the newest outcome in the LSB
    logic [num_ghr_bits-1:0] ghr_q;

    // one 2-bit saturating counter per history pattern
    logic [1:0] pht_q [num_counters];

    logic [1:0] train_count;

    // gshare hashing mixes the history into the low PC bits
    // the pipeline carries this index to resolve so training hits the same counter
    assign pht_index_o = ghr_q ^ pc_i[pc_offset_bits +: num_ghr_bits];

    // the MSB of the counter is the direction
    assign pht_taken_o = pht_q[pht_index_o][1];

    // counter being trained this cycle
    assign train_count = pht_q[update_index_i];

    // a clear overrides the shift when both arrive together
    // the shift drops the oldest outcome out of the MSB
    always_ff @(posedge clk) begin
        if (reset_i || ghr_clear_i) begin
            ghr_q <= '0;
        end else if (update_i) begin
            ghr_q <= (ghr_q << 1) | num_ghr_bits'(taken_i);
        end
    end

    // the counters start weakly not taken so they are reset as control state
    // training saturates at both ends of the range
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < num_counters; i++) begin
                pht_q[i] <= pht_reset_state;
            end
        end else if (update_i) begin
            if (taken_i) begin
                if (train_count != pht_max) begin
                    pht_q[update_index_i] <= train_count + 2'd1;
                end
            end else begin
                if (train_count != pht_min) begin
                    pht_q[update_index_i] <= train_count - 2'd1;
                end
            end
        end
    end

    // a clear still trains a counter in the same cycle
    // the history however must come out empty whatever else happened
    a_ghr_cleared: assert property (@(posedge clk)
        (reset_i || ghr_clear_i) |=> (ghr_q == '0));

endmodule

//--- rtl/bp_pkg.sv
package bp_pkg;

    // width of every address and data word handled by the predictor
    localparam int unsigned xlen = 32;

    // major opcodes of the control transfer instructions seen at fetch
    // conditional branches take their direction from the pattern history table
    localparam logic [6:0] op_branch = 7'b1100011;

    // unconditional jumps are always predicted taken once the BTB knows them
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_jalr = 7'b1100111;

    // instructions are word aligned so the two lowest PC bits never vary
    // both the BTB set index and the gshare index start just above them
    localparam int unsigned pc_offset_bits = 2;

    // 2-bit saturating counter encodings
    // 00 strongly not taken
    // 01 weakly not taken
    // 10 weakly taken
    // 11 strongly taken
    // the counter MSB is the direction prediction
    localparam logic [1:0] pht_min = 2'b00;
    localparam logic [1:0] pht_reset_state = 2'b01;
    localparam logic [1:0] pht_max = 2'b11;

    // every counter starts weakly not taken so one taken outcome flips it
    // a freshly reset table therefore needs little training to follow a loop

    // the tag stored per BTB entry is every PC bit above the set index
    // its width depends on the number of sets and is worked out in each way

    // the branch offset of a taken branch is not decoded here
    // the BTB supplies the whole target address instead
    // this keeps the fetch path free of an adder on the immediate field

    // the sequential fall-through is pc plus 4 since compressed code is not supported

endpackage

//--- rtl/bp_predict_merge.sv
module bp_predict_merge import bp_pkg::*; #(
    parameter int unsigned num_ways = 2
) (
    input  logic [xlen-1:0]          pc_i,
    input  logic [6:0]               op_i,
    input  logic [num_ways-1:0]      way_hit_i,
    input  logic [num_ways*xlen-1:0] way_target_i,
    input  logic                     pht_taken_i,
    output logic                     predict_taken_o,
    output logic [xlen-1:0]          predict_target_o
);

    logic            any_hit;
    logic [xlen-1:0] hit_target;
    logic            is_jump;

    // jumps always redirect once the BTB knows their target
    assign is_jump = (op_i == op_jal) || (op_i == op_jalr);

    // pick the target of whichever way hit
    // at most one way can hit because a set never holds a tag twice
    always_comb begin
        any_hit    = 1'b0;
        hit_target = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (way_hit_i[w]) begin
                any_hit    = 1'b1;
                hit_target = way_target_i[w*xlen +: xlen];
            end
        end
    end

    // conditional branches and any other opcode follow the counter MSB
    // a miss always falls through to the next sequential word
    always_comb begin
        if (any_hit) begin
            predict_taken_o  = is_jump || pht_taken_i;
            predict_target_o = hit_target;
        end else begin
            predict_taken_o  = 1'b0;
            predict_target_o = pc_i + xlen'(4);
        end
    end

    // the fill logic keeps the tags of a set distinct across all ways
    always_comb begin
        a_single_hit: assert final ($onehot0(way_hit_i))
            else $error("more than one BTB way hit for pc %h", pc_i);
    end

endmodule

//--- rtl/bp_predictor.sv
module bp_predictor import bp_pkg::*; #(
    parameter int unsigned num_sets     = 16,
    parameter int unsigned num_ways     = 2,
    parameter int unsigned num_ghr_bits = 5
) (
    input  logic                    clk,
    input  logic                    reset_i,
    // fetch side lookup
    input  logic [xlen-1:0]         pc_i,
    input  logic [6:0]              op_i,
    // BTB write from resolve
    input  logic                    btb_update_i,
    input  logic [xlen-1:0]         btb_update_pc_i,
    input  logic [xlen-1:0]         btb_update_target_i,
    // direction training from resolve
    input  logic                    pht_update_i,
    input  logic [num_ghr_bits-1:0] pht_update_index_i,
    input  logic                    taken_i,
    input  logic                    ghr_clear_i,
    // prediction back to fetch
    output logic                    predict_taken_o,
    output logic [xlen-1:0]         predict_target_o,
    output logic [num_ghr_bits-1:0] pht_index_o
);

    // per-way lookup results flattened way by way
    logic [num_ways-1:0]      way_hit;
    logic [num_ways*xlen-1:0] way_target;

    // per-way update compare and the write select built from it
    logic [num_ways-1:0] update_match;
    logic [num_ways-1:0] way_write;

    logic pht_taken;

    // decides which way takes a BTB write
    bp_btb_fill #(
        .num_sets (num_sets),
        .num_ways (num_ways)
    ) i_fill (
        .clk            (clk),
        .reset_i        (reset_i),
        .update_i       (btb_update_i),
        .update_pc_i    (btb_update_pc_i),
        .update_match_i (update_match),
        .way_write_o    (way_write)
    );

    // the BTB ways all see the same lookup and update addresses
    for (genvar w = 0; w < num_ways; w++) begin : g_way
        bp_btb_way #(
            .num_sets (num_sets)
        ) i_way (
            .clk             (clk),
            .reset_i         (reset_i),
            .lookup_pc_i     (pc_i),
            .update_pc_i     (btb_update_pc_i),
            .update_target_i (btb_update_target_i),
            .write_i         (way_write[w]),
            .lookup_hit_o    (way_hit[w]),
            .lookup_target_o (way_target[w*xlen +: xlen]),
            .update_match_o  (update_match[w])
        );
    end

    // direction predictor with its own history
    bp_gshare #(
        .num_ghr_bits (num_ghr_bits)
    ) i_gshare (
        .clk            (clk),
        .reset_i        (reset_i),
        .pc_i           (pc_i),
        .update_i       (pht_update_i),
        .update_index_i (pht_update_index_i),
        .taken_i        (taken_i),
        .ghr_clear_i    (ghr_clear_i),
        .pht_index_o    (pht_index_o),
        .pht_taken_o    (pht_taken)
    );

    // combines the BTB hit with the direction into the fetch redirect
    bp_predict_merge #(
        .num_ways (num_ways)
    ) i_merge (
        .pc_i             (pc_i),
        .op_i             (op_i),
        .way_hit_i        (way_hit),
        .way_target_i     (way_target),
        .pht_taken_i      (pht_taken),
        .predict_taken_o  (predict_taken_o),
        .predict_target_o (predict_target_o)
    );

endmodule

//--- sim/bp_tb.sv
module bp_tb import bp_pkg::*;;

    localparam int unsigned num_sets     = 16;
    localparam int unsigned num_ways     = 2;
    localparam int unsigned num_ghr_bits = 5;
    localparam int          half_period  = 4;

    logic                    clk;
    logic                    reset_i;
    logic [xlen-1:0]         pc_i;
    logic [6:0]              op_i;
    logic                    btb_update_i;
    logic [xlen-1:0]         btb_update_pc_i;
    logic [xlen-1:0]         btb_update_target_i;
    logic                    pht_update_i;
    logic [num_ghr_bits-1:0] pht_update_index_i;
    logic                    taken_i;
    logic                    ghr_clear_i;
    logic                    predict_taken_o;
    logic [xlen-1:0]         predict_target_o;
    logic [num_ghr_bits-1:0] pht_index_o;

    // reference state, tags are kept as the full PC divided by the set span
    logic [xlen-1:0]         ref_target [num_ways][num_sets];
    logic [xlen-1:0]         ref_tag    [num_ways][num_sets];
    logic                    ref_valid  [num_ways][num_sets];
    int                      ref_rr     [num_sets];
    logic [1:0]              ref_pht    [2**num_ghr_bits];
    logic [num_ghr_bits-1:0] ref_ghr;

    integer seed;
    int     cycles_checked;

    bp_predictor #(
        .num_sets     (num_sets),
        .num_ways     (num_ways),
        .num_ghr_bits (num_ghr_bits)
    ) i_dut (
        .clk                 (clk),
        .reset_i             (reset_i),
        .pc_i                (pc_i),
        .op_i                (op_i),
        .btb_update_i        (btb_update_i),
        .btb_update_pc_i     (btb_update_pc_i),
        .btb_update_target_i (btb_update_target_i),
        .pht_update_i        (pht_update_i),
        .pht_update_index_i  (pht_update_index_i),
        .taken_i             (taken_i),
        .ghr_clear_i         (ghr_clear_i),
        .predict_taken_o     (predict_taken_o),
        .predict_target_o    (predict_target_o),
        .pht_index_o         (pht_index_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(half_period) clk = ~clk;
        end
    end

    // word address modulo the set count picks the set
    function automatic int set_of(input logic [xlen-1:0] pc);
        return int'((pc / xlen'(4)) % xlen'(num_sets));
    endfunction

    function automatic logic [xlen-1:0] tag_of(input logic [xlen-1:0] pc);
        return pc / xlen'(4 * num_sets);
    endfunction

    // returns the way holding this PC, or -1 on a miss
    function automatic int find_way(input logic [xlen-1:0] pc);
        int s;
        int hit;
        s = set_of(pc);
        hit = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (ref_valid[w][s] && (ref_tag[w][s] == tag_of(pc))) begin
                hit = w;
            end
        end
        return hit;
    endfunction

    // history XOR the low bits of the word address
    function automatic logic [num_ghr_bits-1:0] expected_index(input logic [xlen-1:0] pc);
        return ref_ghr ^ num_ghr_bits'(pc / xlen'(4));
    endfunction

    function automatic logic expected_taken(input logic [xlen-1:0] pc, input logic [6:0] op);
        if (find_way(pc) < 0) begin
            return 1'b0;
        end
        if ((op == op_jal) || (op == op_jalr)) begin
            return 1'b1;
        end
        return ref_pht[expected_index(pc)][1];
    endfunction

    function automatic logic [xlen-1:0] expected_target(input logic [xlen-1:0] pc);
        int w;
        w = find_way(pc);
        if (w < 0) begin
            return pc + xlen'(4);
        end
        return ref_target[w][set_of(pc)];
    endfunction

    task automatic reset_model();
        for (int s = 0; s < num_sets; s++) begin
            ref_rr[s] = 0;
            for (int w = 0; w < num_ways; w++) begin
                ref_valid[w][s] = 1'b0;
            end
        end
        for (int i = 0; i < 2**num_ghr_bits; i++) begin
            ref_pht[i] = pht_reset_state;
        end
        ref_ghr = '0;
    endtask

    // applies the strobes that the DUT samples at the coming rising edge
    task automatic advance_model();
        int s;
        int w;
        int idx;
        if (btb_update_i) begin
            s = set_of(btb_update_pc_i);
            w = find_way(btb_update_pc_i);
            if (w < 0) begin
                w = ref_rr[s];
                ref_rr[s] = (ref_rr[s] + 1) % num_ways;
            end
            ref_valid[w][s] = 1'b1;
            ref_tag[w][s] = tag_of(btb_update_pc_i);
            ref_target[w][s] = btb_update_target_i;
        end
        if (pht_update_i) begin
            idx = int'(pht_update_index_i);
            if (taken_i && (ref_pht[idx] != pht_max)) begin
                ref_pht[idx] = ref_pht[idx] + 2'd1;
            end else if (!taken_i && (ref_pht[idx] != pht_min)) begin
                ref_pht[idx] = ref_pht[idx] - 2'd1;
            end
        end
        if (ghr_clear_i) begin
            ref_ghr = '0;
        end else if (pht_update_i) begin
            ref_ghr = {ref_ghr[num_ghr_bits-2:0], taken_i};
        end
    endtask

    task automatic check_value(input logic [xlen-1:0] actual, input logic [xlen-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at the first wrong output");
        end
    endtask

    // outputs are combinational, so they are settled one time unit before the rising edge
    initial begin
        forever begin
            @(negedge clk);
            #(half_period - 1);
            if (reset_i) begin
                reset_model();
            end else begin
                check_value(32'(predict_taken_o), 32'(expected_taken(pc_i, op_i)),
                            "predict_taken_o");
                check_value(predict_target_o, expected_target(pc_i), "predict_target_o");
                check_value(32'(pht_index_o), 32'(expected_index(pc_i)), "pht_index_o");
                advance_model();
                cycles_checked++;
            end
        end
    end

    task automatic wait_checks(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (cycles_checked < target) begin
            if (n >= limit) begin
                $display("timed out waiting for %s", what);
                $display("TESTBENCH FAILED");
                $fatal(1, "compare process stalled");
            end else begin
                @(posedge clk);
                n++;
            end
        end
    endtask

    task automatic drive_cycle(
        input logic [xlen-1:0]         pc,
        input logic [6:0]              op,
        input logic                    btb_upd,
        input logic [xlen-1:0]         btb_pc,
        input logic [xlen-1:0]         btb_tgt,
        input logic                    pht_upd,
        input logic [num_ghr_bits-1:0] idx,
        input logic                    tk,
        input logic                    clr
    );
        @(negedge clk);
        pc_i = pc;
        op_i = op;
        btb_update_i = btb_upd;
        btb_update_pc_i = btb_pc;
        btb_update_target_i = btb_tgt;
        pht_update_i = pht_upd;
        pht_update_index_i = idx;
        taken_i = tk;
        ghr_clear_i = clr;
    endtask

    task automatic lookup(input logic [xlen-1:0] pc, input logic [6:0] op);
        drive_cycle(pc, op, 1'b0, '0, '0, 1'b0, '0, 1'b0, 1'b0);
    endtask

    // the lookup in the write cycle must still see the old entry
    task automatic write_btb(input logic [xlen-1:0] pc, input logic [xlen-1:0] tgt);
        drive_cycle(pc, op_jal, 1'b1, pc, tgt, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic train(input logic [xlen-1:0] pc, input logic [num_ghr_bits-1:0] idx,
                         input logic tk, input logic clr);
        drive_cycle(pc, op_branch, 1'b0, '0, '0, 1'b1, idx, tk, clr);
    endtask

    task automatic clear_history(input logic [xlen-1:0] pc);
        drive_cycle(pc, op_branch, 1'b0, '0, '0, 1'b0, '0, 1'b0, 1'b1);
    endtask

    function automatic logic [6:0] random_op();
        int pick;
        pick = $random(seed) & 3;
        case (pick)
            0: return op_branch;
            1: return op_jal;
            2: return op_jalr;
            default: return 7'($random(seed));
        endcase
    endfunction

    // a narrow tag range keeps sets contended so evictions happen often
    function automatic logic [xlen-1:0] random_pc();
        return 32'h8000_0000 | (32'($random(seed)) & 32'h0000_03fc);
    endfunction

    initial begin
        logic [xlen-1:0]         pc_a;
        logic [xlen-1:0]         pc_b;
        logic [num_ghr_bits-1:0] idx_b;
        logic                    r_btb;
        logic                    r_pht;
        logic                    r_clr;
        seed = 47;
        cycles_checked = 0;
        reset_i = 1'b1;
        pc_i = '0;
        op_i = '0;
        btb_update_i = 1'b0;
        btb_update_pc_i = '0;
        btb_update_target_i = '0;
        pht_update_i = 1'b0;
        pht_update_index_i = '0;
        taken_i = 1'b0;
        ghr_clear_i = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        wait_checks(1, 10, "the first check after reset");

        // empty BTB falls through for every opcode
        for (int n = 0; n < 20; n++) begin
            lookup(32'($random(seed)), random_op());
        end

        // jal and jalr hit after a write, another tag in the set misses
        pc_a = 32'h0000_1048;
        write_btb(pc_a, 32'h0000_2000);
        lookup(pc_a, op_jal);
        lookup(pc_a, op_jalr);
        lookup(pc_a + 32'h40, op_jal);

        // third tag evicts the oldest, a rewrite stays in place
        write_btb(pc_a + 32'h40, 32'h0000_3000);
        write_btb(pc_a + 32'h80, 32'h0000_4000);
        lookup(pc_a, op_jal);
        lookup(pc_a + 32'h40, op_jalr);
        write_btb(pc_a + 32'h40, 32'h0000_5000);
        lookup(pc_a + 32'h40, op_jal);
        lookup(pc_a + 32'h80, op_jal);
        write_btb(pc_a + 32'hc0, 32'h0000_6000);
        lookup(pc_a + 32'h40, op_jal);
        lookup(pc_a + 32'h80, op_jal);
        lookup(pc_a + 32'hc0, op_jal);

        // branch direction follows the counter, which saturates at both ends
        pc_b = 32'h0000_0a14;
        idx_b = num_ghr_bits'(pc_b / xlen'(4));
        write_btb(pc_b, 32'h0000_0100);
        for (int n = 0; n < 4; n++) begin
            train(pc_b, idx_b, 1'b1, 1'b0);
        end
        clear_history(pc_b);
        lookup(pc_b, op_branch);
        for (int n = 0; n < 5; n++) begin
            train(pc_b, idx_b, 1'b0, 1'b1);
            lookup(pc_b, op_branch);
        end

        // history shifts on training, and a clear wins over a coinciding shift
        for (int n = 0; n < 8; n++) begin
            train(random_pc(), 5'($random(seed)), 1'($random(seed)), 1'b0);
            lookup(random_pc(), op_branch);
        end
        train(pc_b, idx_b, 1'b1, 1'b1);
        lookup(pc_b, op_branch);
        lookup(random_pc(), op_branch);

        // mixed random traffic
        for (int n = 0; n < 2000; n++) begin
            r_btb = (($random(seed) & 3) == 0);
            r_pht = (($random(seed) & 1) == 0);
            r_clr = (($random(seed) & 15) == 0);
            drive_cycle(random_pc(), random_op(), r_btb, random_pc(),
                        32'($random(seed)) & 32'hffff_fffc, r_pht, 5'($random(seed)),
                        1'($random(seed)), r_clr);
        end
        lookup(random_pc(), random_op());
        wait_checks(cycles_checked + 2, 10, "the last checks");
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- tb.f
rtl/bp_pkg.sv
rtl/bp_btb_way.sv
rtl/bp_btb_fill.sv
rtl/bp_predict_merge.sv
rtl/bp_gshare.sv
rtl/bp_predictor.sv
sim/bp_tb.sv
